//--- build.f
hw/vnarrow_pkg.sv
hw/vec_beat_if.sv
hw/vnarrow_shift.sv
hw/vnarrow.sv
hw/vnarrow_merge.sv
hw/vnarrow_top.sv
testbench/vnarrow_checker.sv
testbench/vnarrow_tb.sv

//--- hw/vec_beat_if.sv
`timescale 1ns/1ns

interface vec_beat_if;

  logic                valid;
  vnarrow_pkg::data_t  data;
  vnarrow_pkg::sew_t   sew;
  vnarrow_pkg::be_t    be;

  // Producer side
  modport src (
    output valid,
    output data,
    output sew,
    output be
  );

  // Consumer side, no ready so the beat must be taken when valid
  modport dst (
    input valid,
    input data,
    input sew,
    input be
  );

endinterface

//--- hw/vnarrow.sv
`timescale 1ns/1ns

module vnarrow #(
  parameter bit ENABLE_64_BIT = 1'b1
) (
  input  logic     clk,
  input  logic     rst,
  vec_beat_if.dst  i_beat,
  vec_beat_if.src  o_beat,
  output logic     o_upper
);

  localparam int DATA_W  = vnarrow_pkg::DATA_W;
  localparam int HALF_W  = vnarrow_pkg::HALF_W;
  localparam int HALF_BE = vnarrow_pkg::HALF_BE;
  localparam int NUM_SEW = vnarrow_pkg::NUM_SEW;

  // Packed low halves of the elements, one per source width
  vnarrow_pkg::half_t    halves [NUM_SEW];
  vnarrow_pkg::half_t    half_sel;
  vnarrow_pkg::half_be_t half_be;
  logic                  turn;

  // Lower half first, idle cycles leave it alone
  always_ff @(posedge clk) begin
    if (rst) begin
      turn <= 1'b0;
    end else if (i_beat.valid) begin
      turn <= ~turn;
    end
  end

  assign halves[vnarrow_pkg::SEW_8] = '0;

  for (genvar j = 1; j < NUM_SEW; j++) begin : g_sew
    localparam int W = 8 << j;

    if (j == NUM_SEW - 1 && !ENABLE_64_BIT) begin : g_off
      assign halves[j] = '0;
    end else begin : g_on
      // Element k keeps its low half at slot k
      for (genvar k = 0; k < DATA_W / W; k++) begin : g_elem
        assign halves[j][k*W/2 +: W/2] = i_beat.data[k*W +: W/2];
      end
    end
  end

  // Even source bytes carry the enables of the low halves
  for (genvar m = 0; m < HALF_BE; m++) begin : g_be
    assign half_be[m] = i_beat.be[2*m];
  end

  assign half_sel = halves[i_beat.sew];

  always_comb begin
    if (turn) begin
      o_beat.data = {half_sel, {HALF_W{1'b0}}};
      o_beat.be   = {half_be, {HALF_BE{1'b0}}};
    end else begin
      o_beat.data = {{HALF_W{1'b0}}, half_sel};
      o_beat.be   = {{HALF_BE{1'b0}}, half_be};
    end
  end

  assign o_beat.valid = i_beat.valid;
  assign o_beat.sew   = i_beat.sew - 2'd1;
  assign o_upper      = turn;

endmodule

//--- hw/vnarrow_merge.sv
`timescale 1ns/1ns

module vnarrow_merge (
  input  logic                clk,
  input  logic                rst,
  vec_beat_if.dst             i_beat,
  input  logic                i_upper,
  output vnarrow_pkg::data_t  o_vec,
  output vnarrow_pkg::be_t    o_be,
  output vnarrow_pkg::sew_t   o_sew,
  output logic                o_valid
);

  // Lower half waiting for its partner
  vnarrow_pkg::data_t acc_data;
  vnarrow_pkg::be_t   acc_be;

  vnarrow_pkg::data_t merged_data;
  vnarrow_pkg::be_t   merged_be;
  logic               lower_beat;
  logic               upper_beat;

  assign lower_beat = i_beat.valid & ~i_upper;
  assign upper_beat = i_beat.valid & i_upper;

  // Halves never overlap, so OR is enough
  assign merged_data = acc_data | i_beat.data;
  assign merged_be   = acc_be | i_beat.be;

  always_ff @(posedge clk) begin
    if (rst) begin
      acc_data <= '0;
      acc_be   <= '0;
    end else if (lower_beat) begin
      acc_data <= i_beat.data;
      acc_be   <= i_beat.be;
    end else if (upper_beat) begin
      acc_data <= '0;
      acc_be   <= '0;
    end
  end

  // One cycle pulse per completed pair
  always_ff @(posedge clk) begin
    if (rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= upper_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (upper_beat) begin
      o_vec <= merged_data;
      o_be  <= merged_be;
      o_sew <= i_beat.sew;
    end
  end

endmodule

//--- hw/vnarrow_pkg.sv
package vnarrow_pkg;

  // Beat and result word geometry
  localparam int DATA_W  = 64;
  localparam int BE_W    = DATA_W / 8;
  localparam int HALF_W  = DATA_W / 2;
  localparam int HALF_BE = BE_W / 2;

  // Element width encoding
  localparam int SEW_W   = 2;
  localparam int NUM_SEW = 1 << SEW_W;

  // Shift amount covers up to 64-bit elements
  localparam int SHAMT_W = 6;

  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [HALF_W-1:0]  half_t;
  typedef logic [BE_W-1:0]    be_t;
  typedef logic [HALF_BE-1:0] half_be_t;
  typedef logic [SEW_W-1:0]   sew_t;
  typedef logic [SHAMT_W-1:0] shamt_t;

  // Code n means 8 << n bit elements
  localparam sew_t SEW_8  = 2'd0;
  localparam sew_t SEW_16 = 2'd1;
  localparam sew_t SEW_32 = 2'd2;
  localparam sew_t SEW_64 = 2'd3;

endpackage

//--- hw/vnarrow_shift.sv
`timescale 1ns/1ns

module vnarrow_shift #(
  parameter bit ENABLE_64_BIT = 1'b1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  vnarrow_pkg::data_t   i_vec,
  input  logic                 i_valid,
  input  vnarrow_pkg::sew_t    i_sew,
  input  vnarrow_pkg::be_t     i_be,
  input  vnarrow_pkg::shamt_t  i_shamt,
  input  logic                 i_arith,
  vec_beat_if.src              o_beat
);

  localparam int DATA_W  = vnarrow_pkg::DATA_W;
  localparam int NUM_SEW = vnarrow_pkg::NUM_SEW;

  // Shifted beat for every element width, picked by i_sew below
  vnarrow_pkg::data_t shifted [NUM_SEW];

  // 8-bit elements have no narrow result, next stage zeroes them
  assign shifted[vnarrow_pkg::SEW_8] = i_vec;

  for (genvar j = 1; j < NUM_SEW; j++) begin : g_sew
    localparam int W  = 8 << j;
    localparam int AW = 3 + j;

    if (j == NUM_SEW - 1 && !ENABLE_64_BIT) begin : g_off
      assign shifted[j] = i_vec;
    end else begin : g_on
      for (genvar k = 0; k < DATA_W / W; k++) begin : g_elem
        logic [2*W-1:0] ext;
        logic           fill;

        // Sign bit replicated above the element for sra
        assign fill = i_arith & i_vec[k*W + W - 1];
        assign ext  = {{W{fill}}, i_vec[k*W +: W]};

        // Amount taken modulo the element width
        assign shifted[j][k*W +: W] = W'(ext >> i_shamt[AW-1:0]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_beat.valid <= 1'b0;
    end else begin
      o_beat.valid <= i_valid;
    end
  end

  // Payload is only meaningful alongside valid
  always_ff @(posedge clk) begin
    if (i_valid) begin
      o_beat.data <= shifted[i_sew];
      o_beat.sew  <= i_sew;
      o_beat.be   <= i_be;
    end
  end

endmodule

//--- hw/vnarrow_top.sv
`timescale 1ns/1ns

module vnarrow_top #(
  parameter bit ENABLE_64_BIT = 1'b1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  vnarrow_pkg::data_t   i_vec,
  input  logic                 i_valid,
  input  vnarrow_pkg::sew_t    i_sew,
  input  vnarrow_pkg::be_t     i_be,
  input  vnarrow_pkg::shamt_t  i_shamt,
  input  logic                 i_arith,
  output vnarrow_pkg::data_t   o_vec,
  output vnarrow_pkg::be_t     o_be,
  output vnarrow_pkg::sew_t    o_sew,
  output logic                 o_valid
);

  // Shift stage output, source width
  vec_beat_if shifted_beat ();
  // Narrowed half beat, result width
  vec_beat_if narrow_beat ();

  logic upper;

  vnarrow_shift #(
    .ENABLE_64_BIT (ENABLE_64_BIT)
  ) u_shift (
    .clk     (clk),
    .rst     (rst),
    .i_vec   (i_vec),
    .i_valid (i_valid),
    .i_sew   (i_sew),
    .i_be    (i_be),
    .i_shamt (i_shamt),
    .i_arith (i_arith),
    .o_beat  (shifted_beat.src)
  );

  vnarrow #(
    .ENABLE_64_BIT (ENABLE_64_BIT)
  ) u_narrow (
    .clk     (clk),
    .rst     (rst),
    .i_beat  (shifted_beat.dst),
    .o_beat  (narrow_beat.src),
    .o_upper (upper)
  );

  vnarrow_merge u_merge (
    .clk     (clk),
    .rst     (rst),
    .i_beat  (narrow_beat.dst),
    .i_upper (upper),
    .o_vec   (o_vec),
    .o_be    (o_be),
    .o_sew   (o_sew),
    .o_valid (o_valid)
  );

endmodule

//--- testbench/vnarrow_checker.sv
`timescale 1ns/1ns

module vnarrow_checker (
  input logic               clk,
  input logic               rst,
  input logic               i_valid,
  input vnarrow_pkg::sew_t  i_sew,
  input logic               i_res_valid,
  input vnarrow_pkg::sew_t  i_res_sew
);

  int                fail_count = 0;
  logic              second_half;
  logic              closing_beat;

  // Pairing tracked apart from the DUT turn flag
  always_ff @(posedge clk) begin
    if (rst) begin
      second_half <= 1'b0;
    end else if (i_valid) begin
      second_half <= ~second_half;
    end
  end

  assign closing_beat = i_valid & second_half;

  a_reset_quiet: assert property (@(posedge clk) rst |=> !i_res_valid) else begin
    $error("result valid seen during reset");
    fail_count++;
  end

  a_after_reset: assert property (@(posedge clk) $fell(rst) |=> !i_res_valid) else begin
    $error("result valid seen in the first cycle after reset");
    fail_count++;
  end

  // Result two edges after the closing beat, and never otherwise
  a_pair_timing: assert property (@(posedge clk) disable iff (rst)
    i_res_valid == $past(closing_beat, 2)) else begin
    $error("result valid does not follow the closing beat of a pair");
    fail_count++;
  end

  a_single_pulse: assert property (@(posedge clk) disable iff (rst)
    i_res_valid |=> !i_res_valid) else begin
    $error("result valid held for two cycles");
    fail_count++;
  end

  a_result_sew: assert property (@(posedge clk) disable iff (rst)
    i_res_valid |-> i_res_sew == vnarrow_pkg::sew_t'($past(i_sew, 2) - 2'd1)) else begin
    $error("result sew is not one code below the input sew");
    fail_count++;
  end

endmodule

bind vnarrow_top vnarrow_checker u_checker (
  .clk         (clk),
  .rst         (rst),
  .i_valid     (i_valid),
  .i_sew       (i_sew),
  .i_res_valid (o_valid),
  .i_res_sew   (o_sew)
);

//--- testbench/vnarrow_tb.sv
`timescale 1ns/1ns

module vnarrow_tb;

  localparam int NUM_PAIRS = 300;
  // 300 pairs at up to 8 cycles each, plus directed gaps and drain
  localparam int TIMEOUT_CYCLES = 3000;

  logic                 clk;
  logic                 rst;
  vnarrow_pkg::data_t   i_vec;
  logic                 i_valid;
  vnarrow_pkg::sew_t    i_sew;
  vnarrow_pkg::be_t     i_be;
  vnarrow_pkg::shamt_t  i_shamt;
  logic                 i_arith;
  vnarrow_pkg::data_t   o_vec;
  vnarrow_pkg::be_t     o_be;
  vnarrow_pkg::sew_t    o_sew;
  logic                 o_valid;

  logic [31:0]          rng_state;
  int                   cycle_count;
  int                   sb_errors;
  int                   timeout_errors;
  int                   pairs_sent;
  int                   results_seen;

  vnarrow_pkg::data_t   exp_vec [$];
  vnarrow_pkg::be_t     exp_be [$];
  vnarrow_pkg::sew_t    exp_sew [$];

  vnarrow_top #(
    .ENABLE_64_BIT (1'b1)
  ) u_dut (
    .clk     (clk),
    .rst     (rst),
    .i_vec   (i_vec),
    .i_valid (i_valid),
    .i_sew   (i_sew),
    .i_be    (i_be),
    .i_shamt (i_shamt),
    .i_arith (i_arith),
    .o_vec   (o_vec),
    .o_be    (o_be),
    .o_sew   (o_sew),
    .o_valid (o_valid)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic vnarrow_pkg::data_t rand64();
    return {next_rand(), next_rand()};
  endfunction

  // Shift each element, then keep its low half at the same slot
  function automatic vnarrow_pkg::half_t expect_half(
    input vnarrow_pkg::data_t   data,
    input vnarrow_pkg::sew_t    sew,
    input vnarrow_pkg::shamt_t  shamt,
    input logic                 arith
  );
    vnarrow_pkg::half_t half;
    logic [63:0]        elem;
    logic [63:0]        mask;
    int                 w;
    int                 amt;
    half = '0;
    if (sew == vnarrow_pkg::SEW_8) begin
      return half;
    end
    w = 8 << sew;
    amt = shamt % w;
    mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
    for (int k = 0; k < 64 / w; k++) begin
      elem = (data >> (k * w)) & mask;
      if (arith && elem[w-1]) begin
        elem = ((elem >> amt) | ~(mask >> amt)) & mask;
      end else begin
        elem = elem >> amt;
      end
      for (int b = 0; b < w / 2; b++) begin
        half[k * w / 2 + b] = elem[b];
      end
    end
    return half;
  endfunction

  function automatic vnarrow_pkg::half_be_t expect_half_be(input vnarrow_pkg::be_t be);
    vnarrow_pkg::half_be_t hbe;
    for (int m = 0; m < 4; m++) begin
      hbe[m] = be[2*m];
    end
    return hbe;
  endfunction

  task automatic drive_beat(
    input vnarrow_pkg::data_t   data,
    input vnarrow_pkg::sew_t    sew,
    input vnarrow_pkg::be_t     be,
    input vnarrow_pkg::shamt_t  shamt,
    input logic                 arith
  );
    @(posedge clk);
    #1;
    i_valid = 1'b1;
    i_vec   = data;
    i_sew   = sew;
    i_be    = be;
    i_shamt = shamt;
    i_arith = arith;
  endtask

  // Idle cycles carry noise on the payload
  task automatic drive_idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      i_valid = 1'b0;
      i_vec   = rand64();
    end
  endtask

  task automatic send_pair(
    input vnarrow_pkg::sew_t    sew,
    input vnarrow_pkg::data_t   d0,
    input vnarrow_pkg::be_t     b0,
    input vnarrow_pkg::shamt_t  s0,
    input logic                 a0,
    input vnarrow_pkg::data_t   d1,
    input vnarrow_pkg::be_t     b1,
    input vnarrow_pkg::shamt_t  s1,
    input logic                 a1,
    input int                   gap_in,
    input int                   gap_after
  );
    exp_vec.push_back({expect_half(d1, sew, s1, a1), expect_half(d0, sew, s0, a0)});
    exp_be.push_back({expect_half_be(b1), expect_half_be(b0)});
    exp_sew.push_back(vnarrow_pkg::sew_t'(sew - 2'd1));
    drive_beat(d0, sew, b0, s0, a0);
    drive_idle(gap_in);
    drive_beat(d1, sew, b1, s1, a1);
    drive_idle(gap_after);
    pairs_sent++;
  endtask

  task automatic send_random_pair();
    vnarrow_pkg::sew_t sew;
    int                gap_in;
    int                gap_after;
    sew = vnarrow_pkg::sew_t'(1 + next_rand() % 3);
    gap_in = next_rand() % 4;
    gap_after = next_rand() % 4;
    send_pair(sew, rand64(), vnarrow_pkg::be_t'(next_rand()),
              vnarrow_pkg::shamt_t'(next_rand()), 1'(next_rand() % 2),
              rand64(), vnarrow_pkg::be_t'(next_rand()),
              vnarrow_pkg::shamt_t'(next_rand()), 1'(next_rand() % 2),
              gap_in, gap_after);
  endtask

  task automatic check_result();
    vnarrow_pkg::data_t ev;
    vnarrow_pkg::be_t   eb;
    vnarrow_pkg::sew_t  es;
    if (exp_vec.size() == 0) begin
      $display("Result seen at %0t while no pair was waiting for one", $time);
      sb_errors++;
    end else begin
      ev = exp_vec.pop_front();
      eb = exp_be.pop_front();
      es = exp_sew.pop_front();
      assert (o_vec === ev) else begin
        $display("CHECK FAILED at %0t: o_vec is %h, expected %h", $time, o_vec, ev);
        sb_errors++;
      end
      assert (o_be === eb) else begin
        $display("CHECK FAILED at %0t: o_be is %b, expected %b", $time, o_be, eb);
        sb_errors++;
      end
      assert (o_sew === es) else begin
        $display("CHECK FAILED at %0t: o_sew is %0d, expected %0d", $time, o_sew, es);
        sb_errors++;
      end
      results_seen++;
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (o_valid) begin
      check_result();
    end
  end

  task automatic finish_run();
    int total;
    total = sb_errors + u_dut.u_checker.fail_count + timeout_errors;
    $display("Errors: scoreboard %0d, assertions %0d, timeout %0d",
             sb_errors, u_dut.u_checker.fail_count, timeout_errors);
    if (total == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  initial begin : watchdog
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    timeout_errors++;
    finish_run();
  end

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    i_vec          = '0;
    i_valid        = 1'b0;
    i_sew          = vnarrow_pkg::SEW_16;
    i_be           = '0;
    i_shamt        = '0;
    i_arith        = 1'b0;
    rng_state      = 32'heb2b_9471;
    cycle_count    = 0;
    sb_errors      = 0;
    timeout_errors = 0;
    pairs_sent     = 0;
    results_seen   = 0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // Plain truncation with the first pair held open for a while
    send_pair(vnarrow_pkg::SEW_16, rand64(), 8'hFF, 6'd0, 1'b0,
              rand64(), 8'hFF, 6'd0, 1'b0, 6, 1);
    send_pair(vnarrow_pkg::SEW_32, rand64(), 8'hFF, 6'd0, 1'b0,
              rand64(), 8'hFF, 6'd0, 1'b0, 0, 1);
    send_pair(vnarrow_pkg::SEW_64, rand64(), 8'hFF, 6'd0, 1'b0,
              rand64(), 8'hFF, 6'd0, 1'b0, 1, 0);

    // Negative elements shifted past half width in both shift modes
    for (int j = 1; j < 4; j++) begin
      for (int a = 0; a < 2; a++) begin
        send_pair(vnarrow_pkg::sew_t'(j), 64'h8765_C321_FEDC_BA98, 8'hFF,
                  vnarrow_pkg::shamt_t'((8 << j) / 2 + 3), a[0],
                  64'hC0DE_9ABC_F00D_8BAD, 8'hFF, 6'd63, a[0], 0, 1);
      end
    end

    // Sparse enable patterns
    send_pair(vnarrow_pkg::SEW_32, rand64(), 8'h55, 6'd5, 1'b1,
              rand64(), 8'hAA, 6'd7, 1'b0, 0, 0);
    send_pair(vnarrow_pkg::SEW_16, rand64(), 8'h0F, 6'd9, 1'b0,
              rand64(), 8'hF0, 6'd2, 1'b1, 2, 1);

    // Long gaps inside and after a pair
    send_pair(vnarrow_pkg::SEW_16, rand64(), 8'hFF, 6'd3, 1'b1,
              rand64(), 8'h3C, 6'd13, 1'b0, 20, 25);

    while (pairs_sent < NUM_PAIRS) begin
      send_random_pair();
    end
    drive_idle(1);

    while (results_seen < pairs_sent) begin
      @(posedge clk);
    end
    drive_idle(3);
    finish_run();
  end

endmodule
